/* files.f */
hw/mips_pkg.sv
hw/stage_reg.sv
hw/fetch.sv
hw/decode.sv
hw/execute.sv
hw/regfile.sv
hw/bypass.sv
hw/control.sv
hw/datapath.sv
sim/tb_datapath.sv

/* hw/bypass.sv */
`timescale 1ns/1ps

module bypass import mips_pkg::*; (
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    input  word_t     rf_a,
    input  word_t     rf_b,
    input  logic      ex_valid,
    input  logic      ex_write,
    input  logic      ex_load,
    input  logic      ex_finish,
    input  reg_addr_t ex_dst,
    input  word_t     ex_result,
    input  logic      rt_write,
    input  reg_addr_t rt_dst,
    input  word_t     rt_result,
    output word_t     rs_data,
    output word_t     rt_data,
    output logic      data_hazard
);

    logic ex_fwd;
    logic rt_fwd;

    // r0 producers never forward
    assign ex_fwd = ex_valid && ex_write && ex_dst != '0;
    assign rt_fwd = rt_write && rt_dst != '0;

    // youngest producer wins
    assign rs_data = (ex_fwd && ex_dst == rs_addr) ? ex_result :
                     (rt_fwd && rt_dst == rs_addr) ? rt_result : rf_a;
    assign rt_data = (ex_fwd && ex_dst == rt_addr) ? ex_result :
                     (rt_fwd && rt_dst == rt_addr) ? rt_result : rf_b;

    // load still waiting on the data bus
    assign data_hazard = ex_fwd && ex_load && !ex_finish &&
                         (ex_dst == rs_addr || ex_dst == rt_addr);

endmodule

/* hw/control.sv */
`timescale 1ns/1ps

module control (
    input  logic finish_f,
    input  logic finish_e,
    input  logic data_hazard,
    input  logic redirect,
    output logic stall_f,
    output logic stall_d,
    output logic flush_d,
    output logic stall_e,
    output logic flush_e,
    output logic flush_r
);

    logic hold_front;

    // front end waits on execute back-pressure or a load-use hazard
    assign hold_front = !redirect && (!finish_e || data_hazard);

    assign stall_f = hold_front;
    assign stall_d = hold_front;

    // wrong path goes on redirect, empty fetch puts a bubble into F/D
    assign flush_d = redirect || (!finish_f && !hold_front);

    assign stall_e = !redirect && !finish_e;
    // hazard bubble only once execute itself moves on
    assign flush_e = redirect || (finish_e && data_hazard);

    // unfinished execute work must not reach retire
    assign flush_r = !finish_e;

endmodule

/* hw/datapath.sv */
`timescale 1ns/1ps

module datapath import mips_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    // instruction bus
    output logic      ireq,
    output word_t     iaddr,
    input  logic      idata_ok,
    input  word_t     idata,
    // data bus
    output logic      dreq,
    output logic      dwe,
    output word_t     daddr,
    output word_t     dwdata,
    input  logic      ddata_ok,
    input  word_t     drdata,
    // retire
    output logic      rf_wen,
    output reg_addr_t rf_waddr,
    output word_t     rf_wdata,
    output logic      rt_valid,
    output word_t     rt_pc
);

    fetch_data_t  fetch_out;
    fetch_data_t  fd_out;
    decode_data_t decode_out;
    decode_data_t de_out;
    exec_data_t   exec_out;
    exec_data_t   er_out;

    logic      finish_f;
    logic      finish_e;
    logic      data_hazard;
    logic      redirect;
    word_t     target;
    logic      stall_f;
    logic      stall_d;
    logic      flush_d;
    logic      stall_e;
    logic      flush_e;
    logic      flush_r;

    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rf_a;
    word_t     rf_b;
    word_t     rs_data;
    word_t     rt_data;

    // retire stage is the E/R register output
    assign rf_wen   = er_out.valid && er_out.reg_write;
    assign rf_waddr = er_out.dst;
    assign rf_wdata = er_out.result;
    assign rt_valid = er_out.valid;
    assign rt_pc    = er_out.pc;

    fetch u_fetch (
        .clk, .rst,
        .stall    (stall_f),
        .redirect, .target,
        .ireq, .iaddr, .idata_ok, .idata,
        .out      (fetch_out),
        .finish_f
    );

    stage_reg #(.payload_t(fetch_data_t)) u_fd_reg (
        .clk, .rst,
        .stall (stall_d),
        .flush (flush_d),
        .in    (fetch_out),
        .out   (fd_out)
    );

    decode u_decode (
        .in      (fd_out),
        .rs_addr, .rt_addr,
        .rs_data, .rt_data,
        .out     (decode_out)
    );

    stage_reg #(.payload_t(decode_data_t)) u_de_reg (
        .clk, .rst,
        .stall (stall_e),
        .flush (flush_e),
        .in    (decode_out),
        .out   (de_out)
    );

    execute u_execute (
        .clk, .rst,
        .flush  (flush_e),
        .in     (de_out),
        .out    (exec_out),
        .finish_e, .redirect, .target,
        .dreq, .dwe, .daddr, .dwdata, .ddata_ok, .drdata
    );

    stage_reg #(.payload_t(exec_data_t)) u_er_reg (
        .clk, .rst,
        .stall (1'b0),
        .flush (flush_r),
        .in    (exec_out),
        .out   (er_out)
    );

    regfile u_regfile (
        .clk, .rst,
        .wen     (rf_wen),
        .waddr   (rf_waddr),
        .wdata   (rf_wdata),
        .raddr_a (rs_addr),
        .raddr_b (rt_addr),
        .rdata_a (rf_a),
        .rdata_b (rf_b)
    );

    bypass u_bypass (
        .rs_addr, .rt_addr,
        .rf_a, .rf_b,
        .ex_valid  (de_out.valid),
        .ex_write  (de_out.reg_write),
        .ex_load   (de_out.is_load),
        .ex_finish (finish_e),
        .ex_dst    (de_out.dst),
        .ex_result (exec_out.result),
        .rt_write  (rf_wen),
        .rt_dst    (rf_waddr),
        .rt_result (rf_wdata),
        .rs_data, .rt_data,
        .data_hazard
    );

    control u_control (
        .finish_f, .finish_e, .data_hazard, .redirect,
        .stall_f, .stall_d, .flush_d,
        .stall_e, .flush_e, .flush_r
    );

endmodule

/* hw/decode.sv */
`timescale 1ns/1ps

module decode import mips_pkg::*; (
    input  fetch_data_t  in,
    output reg_addr_t    rs_addr,
    output reg_addr_t    rt_addr,
    input  word_t        rs_data,
    input  word_t        rt_data,
    output decode_data_t out
);

    logic [5:0] op;
    logic [5:0] fn;
    reg_addr_t  rd;
    logic [4:0] shamt;
    word_t      imm_sx;
    word_t      imm_zx;

    assign op      = in.instr[31:26];
    assign rs_addr = in.instr[25:21];
    assign rt_addr = in.instr[20:16];
    assign rd      = in.instr[15:11];
    assign shamt   = in.instr[10:6];
    assign fn      = in.instr[5:0];
    assign imm_sx  = {{16{in.instr[15]}}, in.instr[15:0]};
    assign imm_zx  = {16'h0, in.instr[15:0]};

    always_comb begin
        // defaults form a no-op, which is what unknown encodings become
        out           = '0;
        out.valid     = in.valid;
        out.pc        = in.pc;
        out.alu_op    = ALU_ADD;
        out.src_a     = rs_data;
        out.src_b     = rt_data;
        out.imm       = imm_sx;
        out.dst       = rt_addr;

        case (op)
            OP_SPECIAL: begin
                out.dst       = rd;
                out.reg_write = 1'b1;
                case (fn)
                    FN_ADDU: out.alu_op = ALU_ADD;
                    FN_SUBU: out.alu_op = ALU_SUB;
                    FN_AND:  out.alu_op = ALU_AND;
                    FN_OR:   out.alu_op = ALU_OR;
                    FN_XOR:  out.alu_op = ALU_XOR;
                    FN_SLT:  out.alu_op = ALU_SLT;
                    FN_SLL: begin
                        // shift rt by shamt, shamt rides in imm
                        out.alu_op  = ALU_SLL;
                        out.src_a   = rt_data;
                        out.imm     = {27'h0, shamt};
                        out.use_imm = 1'b1;
                    end
                    default: out.reg_write = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                out.use_imm   = 1'b1;
                out.reg_write = 1'b1;
            end
            OP_ORI: begin
                out.alu_op    = ALU_OR;
                out.imm       = imm_zx;
                out.use_imm   = 1'b1;
                out.reg_write = 1'b1;
            end
            OP_LUI: begin
                out.alu_op    = ALU_LUI;
                out.imm       = imm_zx;
                out.use_imm   = 1'b1;
                out.reg_write = 1'b1;
            end
            OP_LW: begin
                out.use_imm   = 1'b1;
                out.reg_write = 1'b1;
                out.is_load   = 1'b1;
            end
            OP_SW: begin
                out.use_imm  = 1'b1;
                out.is_store = 1'b1;
            end
            OP_BEQ: out.is_branch = 1'b1;
            OP_BNE: begin
                out.is_branch = 1'b1;
                out.branch_ne = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

/* hw/execute.sv */
`timescale 1ns/1ps

module execute import mips_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         flush,
    input  decode_data_t in,
    output exec_data_t   out,
    output logic         finish_e,
    output logic         redirect,
    output word_t        target,
    output logic         dreq,
    output logic         dwe,
    output word_t        daddr,
    output word_t        dwdata,
    input  logic         ddata_ok,
    input  word_t        drdata
);

    word_t op_b;
    word_t alu_res;
    word_t addr_q;
    word_t wdata_q;
    logic  we_q;
    logic  issued;
    logic  mem_op;
    logic  taken;

    assign op_b = in.use_imm ? in.imm : in.src_b;

    always_comb begin
        case (in.alu_op)
            ALU_SUB: alu_res = in.src_a - op_b;
            ALU_AND: alu_res = in.src_a & op_b;
            ALU_OR:  alu_res = in.src_a | op_b;
            ALU_XOR: alu_res = in.src_a ^ op_b;
            ALU_SLT: alu_res = {31'h0, $signed(in.src_a) < $signed(op_b)};
            ALU_SLL: alu_res = in.src_a << op_b[4:0];
            ALU_LUI: alu_res = {op_b[15:0], 16'h0};
            default: alu_res = in.src_a + op_b;
        endcase
    end

    // branches compare the raw register operands
    assign taken    = in.is_branch && ((in.src_a == in.src_b) != in.branch_ne);
    assign redirect = in.valid && taken;
    assign target   = in.pc + 32'd4 + {in.imm[29:0], 2'b00};

    // once issued, the bus is driven from the captured copy until ddata_ok
    assign mem_op = in.valid && (in.is_load || in.is_store);
    assign dreq   = mem_op || issued;
    assign daddr  = issued ? addr_q : alu_res;
    assign dwe    = issued ? we_q : in.is_store;
    assign dwdata = issued ? wdata_q : in.src_b;

    // memory work finishes with the bus answer
    assign finish_e = !mem_op || ddata_ok;

    assign out.valid     = in.valid;
    assign out.pc        = in.pc;
    assign out.dst       = in.dst;
    assign out.reg_write = in.reg_write;
    assign out.result    = in.is_load ? drdata : alu_res;

    always_ff @(posedge clk) begin
        addr_q  <= daddr;
        we_q    <= dwe;
        wdata_q <= dwdata;
        if (rst) begin
            issued <= 1'b0;
        end else begin
            issued <= dreq && !ddata_ok;
        end
    end

endmodule

/* hw/fetch.sv */
`timescale 1ns/1ps

module fetch import mips_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        stall,
    input  logic        redirect,
    input  word_t       target,
    output logic        ireq,
    output word_t       iaddr,
    input  logic        idata_ok,
    input  word_t       idata,
    output fetch_data_t out,
    output logic        finish_f
);

    // pc is the address of the instruction being fetched or held
    word_t pc;
    word_t req_addr;
    word_t buf_instr;
    logic  run;
    logic  busy;
    logic  stale;
    logic  buf_valid;
    logic  resp;

    // no new request in a redirect cycle, the target goes out next cycle
    assign ireq  = busy || (run && !buf_valid && !redirect);
    // address stays frozen while a request is open, even across a redirect
    assign iaddr = busy ? req_addr : pc;
    assign resp  = idata_ok && !stale;

    assign out.valid = buf_valid || resp;
    assign out.pc    = pc;
    assign out.instr = buf_valid ? buf_instr : idata;
    assign finish_f  = out.valid;

    always_ff @(posedge clk) begin
        req_addr <= iaddr;
        if (resp) begin
            buf_instr <= idata;
        end

        if (rst) begin
            pc        <= RESET_PC;
            run       <= 1'b0;
            busy      <= 1'b0;
            stale     <= 1'b0;
            buf_valid <= 1'b0;
        end else begin
            run <= 1'b1;
            if (redirect) begin
                pc        <= target;
                // an open request now belongs to the old path
                busy      <= ireq && !idata_ok;
                stale     <= ireq && !idata_ok;
                buf_valid <= 1'b0;
            end else begin
                busy <= ireq && !idata_ok;
                if (idata_ok) begin
                    stale <= 1'b0;
                end
                if (out.valid && !stall) begin
                    pc        <= pc + 32'd4;
                    buf_valid <= 1'b0;
                end else if (resp) begin
                    // stalled, park the instruction until decode takes it
                    buf_valid <= 1'b1;
                end
            end
        end
    end

endmodule

/* hw/mips_pkg.sv */
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_SLL = 4'd6,
        ALU_LUI = 4'd7
    } alu_op_t;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // function codes under OP_SPECIAL
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    localparam word_t RESET_PC = 32'h0000_0000;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } fetch_data_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        alu_op_t   alu_op;
        word_t     src_a;
        word_t     src_b;
        word_t     imm;
        logic      use_imm;
        reg_addr_t dst;
        logic      reg_write;
        logic      is_load;
        logic      is_store;
        logic      is_branch;
        // bne when set, beq otherwise
        logic      branch_ne;
    } decode_data_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t dst;
        logic      reg_write;
        word_t     result;
    } exec_data_t;

endpackage

/* hw/regfile.sv */
`timescale 1ns/1ps

module regfile import mips_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      wen,
    input  reg_addr_t waddr,
    input  word_t     wdata,
    input  reg_addr_t raddr_a,
    input  reg_addr_t raddr_b,
    output word_t     rdata_a,
    output word_t     rdata_b
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // same-cycle write shows through on the read ports
    assign rdata_a = (raddr_a == '0)                ? '0    :
                     (wen && waddr == raddr_a)      ? wdata : regs[raddr_a];
    assign rdata_b = (raddr_b == '0)                ? '0    :
                     (wen && waddr == raddr_b)      ? wdata : regs[raddr_b];

endmodule

/* hw/stage_reg.sv */
`timescale 1ns/1ps

module stage_reg import mips_pkg::*; #(
    parameter type payload_t = fetch_data_t
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     stall,
    input  logic     flush,
    input  payload_t in,
    output payload_t out
);

    // only valid is cleared, the rest of the payload just goes stale
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            out.valid <= 1'b0;
        end else if (!stall) begin
            out <= in;
        end
    end

endmodule

/* sim/tb_datapath.sv */
`timescale 1ns/1ps

module tb_datapath import mips_pkg::*; ();

    localparam int RETIRE_TIMEOUT = 200;
    localparam int MEM_WORDS      = 256;

    logic      clk;
    logic      rst;
    logic      ireq;
    word_t     iaddr;
    logic      idata_ok;
    word_t     idata;
    logic      dreq;
    logic      dwe;
    word_t     daddr;
    word_t     dwdata;
    logic      ddata_ok;
    word_t     drdata;
    logic      rf_wen;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;
    logic      rt_valid;
    word_t     rt_pc;

    word_t imem [MEM_WORDS];
    word_t dmem [MEM_WORDS];
    word_t prog [$];

    // expected retire stream from the ISA model
    word_t     exp_pc    [$];
    logic      exp_wen   [$];
    reg_addr_t exp_waddr [$];
    word_t     exp_wdata [$];

    logic [31:0] ilfsr = 32'd88582;
    logic [31:0] dlfsr = 32'd88582;

    datapath u_dut (
        .clk, .rst,
        .ireq, .iaddr, .idata_ok, .idata,
        .dreq, .dwe, .daddr, .dwdata, .ddata_ok, .drdata,
        .rf_wen, .rf_waddr, .rf_wdata, .rt_valid, .rt_pc
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        // taps 32, 22, 2, 1
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t fill_word(word_t addr);
        return {addr[15:0] ^ 16'h5a5a, ~addr[15:0]} ^ {addr[31:16], addr[31:16]};
    endfunction

    function automatic word_t r_type(logic [5:0] fn, reg_addr_t rs, reg_addr_t rt,
                                     reg_addr_t rd, logic [4:0] sh);
        return {OP_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t i_type(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
                                     logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // instruction ROM, answers one cycle after it sees a request plus 0 to 3 waits
    initial begin : imem_model
        logic       req_s;
        logic       ok_s;
        logic       rst_s;
        word_t      addr_s;
        logic       pending;
        logic [1:0] delay;
        idata_ok = 1'b0;
        idata    = '0;
        pending  = 1'b0;
        delay    = '0;
        forever begin
            @(negedge clk);
            req_s  = ireq;
            ok_s   = idata_ok;
            rst_s  = rst;
            addr_s = iaddr;
            @(posedge clk);
            #1;
            idata_ok = 1'b0;
            if (rst_s) begin
                pending = 1'b0;
            end else if (req_s && !ok_s) begin
                if (!pending) begin
                    pending  = 1'b1;
                    ilfsr    = lfsr_next(ilfsr);
                    delay[0] = ilfsr[0];
                    ilfsr    = lfsr_next(ilfsr);
                    delay[1] = ilfsr[0];
                end
                if (delay == 2'd0) begin
                    idata_ok = 1'b1;
                    idata    = imem[addr_s[9:2]];
                    pending  = 1'b0;
                end else begin
                    delay = delay - 2'd1;
                end
            end
        end
    end

    // data RAM, same timing as the ROM, writes land in the answer cycle
    initial begin : dmem_model
        logic       req_s;
        logic       ok_s;
        logic       rst_s;
        logic       we_s;
        word_t      addr_s;
        word_t      wdata_s;
        logic       pending;
        logic [1:0] delay;
        ddata_ok = 1'b0;
        drdata   = '0;
        pending  = 1'b0;
        delay    = '0;
        forever begin
            @(negedge clk);
            req_s   = dreq;
            ok_s    = ddata_ok;
            rst_s   = rst;
            we_s    = dwe;
            addr_s  = daddr;
            wdata_s = dwdata;
            @(posedge clk);
            #1;
            ddata_ok = 1'b0;
            if (rst_s) begin
                pending = 1'b0;
            end else if (req_s && !ok_s) begin
                if (!pending) begin
                    pending  = 1'b1;
                    dlfsr    = lfsr_next(dlfsr);
                    delay[0] = dlfsr[0];
                    dlfsr    = lfsr_next(dlfsr);
                    delay[1] = dlfsr[0];
                end
                if (delay == 2'd0) begin
                    ddata_ok = 1'b1;
                    pending  = 1'b0;
                    if (we_s) begin
                        dmem[addr_s[9:2]] = wdata_s;
                    end else begin
                        drdata = dmem[addr_s[9:2]];
                    end
                end else begin
                    delay = delay - 2'd1;
                end
            end
        end
    end

    task automatic stop_on_error();
        $display("TEST FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(string sig, word_t got, word_t exp);
        assert (got === exp) else begin
            $display("ERROR %s: got %h expected %h", sig, got, exp);
            stop_on_error();
        end
    endtask

    // bus requests and retire outputs must stay quiet through reset
    task automatic apply_reset();
        @(posedge clk);
        #1;
        rst = 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_value("ireq", ireq, 1'b0);
        check_value("dreq", dreq, 1'b0);
        check_value("rf_wen", rf_wen, 1'b0);
        check_value("rt_valid", rt_valid, 1'b0);
        @(posedge clk);
        #1;
        rst = 1'b0;
        // first cycle out of reset, before any fetch request
        @(negedge clk);
        check_value("ireq", ireq, 1'b0);
        check_value("dreq", dreq, 1'b0);
        check_value("rf_wen", rf_wen, 1'b0);
        check_value("rt_valid", rt_valid, 1'b0);
    endtask

    // architectural model, one retire entry per executed instruction
    task automatic run_model();
        word_t     r [32];
        word_t     mem [MEM_WORDS];
        word_t     pc;
        word_t     next_pc;
        word_t     end_pc;
        word_t     ins;
        word_t     a;
        word_t     b;
        word_t     sx;
        word_t     addr;
        word_t     val;
        logic      wr;
        reg_addr_t dst;
        int        i;
        int        steps;
        exp_pc.delete();
        exp_wen.delete();
        exp_waddr.delete();
        exp_wdata.delete();
        for (i = 0; i < 32; i++) begin
            r[i] = '0;
        end
        for (i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_word(i * 4);
        end
        pc     = RESET_PC;
        end_pc = prog.size() * 4;
        steps  = 0;
        while (pc < end_pc && steps < 500) begin
            ins     = prog[pc[31:2]];
            a       = r[ins[25:21]];
            b       = r[ins[20:16]];
            sx      = {{16{ins[15]}}, ins[15:0]};
            addr    = a + sx;
            val     = '0;
            wr      = 1'b0;
            dst     = ins[20:16];
            next_pc = pc + 32'd4;
            case (ins[31:26])
                OP_SPECIAL: begin
                    dst = ins[15:11];
                    wr  = 1'b1;
                    case (ins[5:0])
                        FN_ADDU: val = a + b;
                        FN_SUBU: val = a - b;
                        FN_AND:  val = a & b;
                        FN_OR:   val = a | b;
                        FN_XOR:  val = a ^ b;
                        FN_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        FN_SLL:  val = b << ins[10:6];
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDIU: begin
                    val = a + sx;
                    wr  = 1'b1;
                end
                OP_ORI: begin
                    val = a | {16'h0, ins[15:0]};
                    wr  = 1'b1;
                end
                OP_LUI: begin
                    val = {ins[15:0], 16'h0};
                    wr  = 1'b1;
                end
                OP_LW: begin
                    val = mem[addr[9:2]];
                    wr  = 1'b1;
                end
                OP_SW: mem[addr[9:2]] = b;
                OP_BEQ: begin
                    if (a == b) next_pc = pc + 32'd4 + (sx << 2);
                end
                OP_BNE: begin
                    if (a != b) next_pc = pc + 32'd4 + (sx << 2);
                end
                default: ;
            endcase
            if (wr && dst != 5'd0) r[dst] = val;
            exp_pc.push_back(pc);
            exp_wen.push_back(wr);
            exp_waddr.push_back(dst);
            exp_wdata.push_back(val);
            pc = next_pc;
            steps++;
        end
    endtask

    task automatic wait_retire(string name, int idx);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (rt_valid !== 1'b1) begin
            cycles++;
            if (cycles > RETIRE_TIMEOUT) begin
                $display("%s: retire %0d did not come within %0d cycles",
                         name, idx, RETIRE_TIMEOUT);
                stop_on_error();
            end
            @(negedge clk);
        end
    endtask

    task automatic check_retires(string name);
        int i;
        for (i = 0; i < exp_pc.size(); i++) begin
            wait_retire(name, i);
            check_value("rt_pc", rt_pc, exp_pc[i]);
            check_value("rf_wen", rf_wen, exp_wen[i]);
            if (exp_wen[i]) begin
                check_value("rf_waddr", rf_waddr, exp_waddr[i]);
                check_value("rf_wdata", rf_wdata, exp_wdata[i]);
            end
        end
        $display("%s: %0d retires checked", name, exp_pc.size());
    endtask

    // ROM beyond the program holds zeros, which decode as sll r0 nops
    task automatic run_program(string name);
        int i;
        for (i = 0; i < MEM_WORDS; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : '0;
            dmem[i] = fill_word(i * 4);
        end
        run_model();
        apply_reset();
        check_retires(name);
    endtask

    task automatic test_alu();
        prog.delete();
        prog.push_back(i_type(OP_ADDIU, 0, 1, 16'h1234));
        prog.push_back(i_type(OP_ORI, 0, 2, 16'hf0f0));
        prog.push_back(i_type(OP_LUI, 0, 3, 16'h8001));
        prog.push_back(i_type(OP_ADDIU, 0, 11, 16'hfffb));
        prog.push_back(r_type(FN_ADDU, 1, 2, 4, 0));
        prog.push_back(r_type(FN_SUBU, 1, 2, 5, 0));
        prog.push_back(r_type(FN_AND, 1, 2, 6, 0));
        prog.push_back(r_type(FN_OR, 3, 1, 7, 0));
        prog.push_back(r_type(FN_XOR, 7, 2, 8, 0));
        prog.push_back(r_type(FN_SLT, 5, 1, 9, 0));
        prog.push_back(r_type(FN_SLL, 0, 1, 10, 4));
        prog.push_back(r_type(FN_SLT, 1, 11, 12, 0));
        run_program("alu");
    endtask

    task automatic test_forwarding();
        prog.delete();
        prog.push_back(i_type(OP_ADDIU, 0, 1, 16'h0007));
        prog.push_back(r_type(FN_ADDU, 1, 1, 2, 0));
        prog.push_back(r_type(FN_ADDU, 2, 1, 3, 0));
        prog.push_back(r_type(FN_SUBU, 3, 2, 4, 0));
        prog.push_back(r_type(FN_SLL, 0, 4, 5, 3));
        prog.push_back(r_type(FN_XOR, 5, 3, 6, 0));
        prog.push_back(r_type(FN_ADDU, 6, 1, 1, 0));
        prog.push_back(r_type(FN_OR, 1, 1, 7, 0));
        run_program("forwarding");
    endtask

    task automatic test_load_use();
        prog.delete();
        prog.push_back(i_type(OP_ADDIU, 0, 1, 16'h0040));
        prog.push_back(i_type(OP_ORI, 0, 2, 16'h55aa));
        prog.push_back(i_type(OP_SW, 1, 2, 16'h0004));
        prog.push_back(i_type(OP_LW, 1, 3, 16'h0004));
        prog.push_back(r_type(FN_ADDU, 3, 3, 4, 0));
        prog.push_back(i_type(OP_LW, 1, 5, 16'h0008));
        prog.push_back(r_type(FN_ADDU, 5, 4, 6, 0));
        prog.push_back(i_type(OP_SW, 1, 6, 16'h0000));
        prog.push_back(i_type(OP_LW, 1, 7, 16'h0000));
        prog.push_back(r_type(FN_SUBU, 7, 5, 8, 0));
        prog.push_back(i_type(OP_LW, 1, 9, 16'hfffc));
        prog.push_back(i_type(OP_SW, 1, 9, 16'h0010));
        prog.push_back(i_type(OP_LW, 1, 10, 16'h0010));
        run_program("load_use");
    endtask

    task automatic test_branches();
        prog.delete();
        prog.push_back(i_type(OP_ADDIU, 0, 1, 16'h0003));
        prog.push_back(i_type(OP_ADDIU, 0, 2, 16'h0003));
        // taken forward, skips two
        prog.push_back(i_type(OP_BEQ, 1, 2, 16'h0002));
        prog.push_back(i_type(OP_ADDIU, 0, 3, 16'h0001));
        prog.push_back(i_type(OP_ADDIU, 0, 3, 16'h0002));
        prog.push_back(i_type(OP_ADDIU, 0, 4, 16'h0009));
        prog.push_back(i_type(OP_BNE, 1, 2, 16'h0001));
        prog.push_back(i_type(OP_ADDIU, 0, 5, 16'h0005));
        prog.push_back(i_type(OP_BNE, 4, 1, 16'h0001));
        prog.push_back(i_type(OP_ADDIU, 0, 6, 16'h0006));
        prog.push_back(i_type(OP_BEQ, 1, 4, 16'h0001));
        prog.push_back(i_type(OP_ADDIU, 0, 7, 16'h0007));
        // three trips round a backward loop
        prog.push_back(i_type(OP_ADDIU, 0, 9, 16'h0003));
        prog.push_back(i_type(OP_ADDIU, 9, 9, 16'hffff));
        prog.push_back(i_type(OP_BNE, 9, 0, 16'hfffe));
        prog.push_back(i_type(OP_ADDIU, 9, 10, 16'h0001));
        prog.push_back(i_type(OP_BEQ, 0, 0, 16'h0001));
        prog.push_back(i_type(OP_ADDIU, 0, 11, 16'h000b));
        prog.push_back(i_type(OP_ADDIU, 0, 12, 16'h000c));
        run_program("branches");
    endtask

    task automatic test_zero_reg();
        prog.delete();
        prog.push_back(i_type(OP_ADDIU, 0, 0, 16'h0077));
        prog.push_back(r_type(FN_ADDU, 0, 0, 1, 0));
        prog.push_back(i_type(OP_ORI, 1, 0, 16'h0001));
        prog.push_back(r_type(FN_OR, 0, 0, 2, 0));
        prog.push_back(i_type(OP_LUI, 0, 0, 16'h1234));
        prog.push_back(i_type(OP_ADDIU, 0, 3, 16'h0005));
        prog.push_back(r_type(FN_SLL, 0, 3, 0, 2));
        prog.push_back(r_type(FN_ADDU, 0, 3, 4, 0));
        prog.push_back(i_type(OP_LW, 0, 0, 16'h0010));
        prog.push_back(r_type(FN_ADDU, 0, 3, 5, 0));
        run_program("zero_reg");
    endtask

    initial begin
        rst = 1'b1;
        test_alu();
        test_forwarding();
        test_load_use();
        test_branches();
        test_zero_reg();
        $display("TEST PASSED");
        $finish;
    end

endmodule
